/* common/mipsPkg.sv */
// ====================
// shared constants and types for the single-cycle MIPS32 subset core
// only R-type add/sub/and/or/slt/jr plus lw, sw, beq, j, jal are decoded
// ====================
package mipsPkg;

  // ==================== widths
  localparam int dataWidth    = 32;
  localparam int regAddrWidth = 5;
  // word address into a 128-word data memory
  localparam int memAddrWidth = 7;

  // ==================== opcodes
  localparam logic [5:0] opRType = 6'b000000;
  localparam logic [5:0] opLw    = 6'b100011;
  localparam logic [5:0] opSw    = 6'b101011;
  localparam logic [5:0] opBeq   = 6'b000100;
  localparam logic [5:0] opJ     = 6'b000010;
  localparam logic [5:0] opJal   = 6'b000011;

  // ==================== function codes, R-type only
  localparam logic [5:0] fnAdd = 6'b100000;
  localparam logic [5:0] fnSub = 6'b100010;
  localparam logic [5:0] fnAnd = 6'b100100;
  localparam logic [5:0] fnOr  = 6'b100101;
  localparam logic [5:0] fnSlt = 6'b101010;
  localparam logic [5:0] fnJr  = 6'b001000;

  // jal destination
  localparam logic [regAddrWidth-1:0] linkReg = 5'd31;

  // alu operation select
  typedef enum logic [2:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluOr,
    aluSlt,
    aluNone
  } aluOp_t;

  // register format
  typedef struct packed {
    logic [5:0] opcode;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt;
    logic [5:0] funct;
  } rFields_t;

  // immediate format, lw/sw/beq
  typedef struct packed {
    logic [5:0]  opcode;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] imm;
  } iFields_t;

  // jump format, j/jal
  typedef struct packed {
    logic [5:0]  opcode;
    logic [25:0] target;
  } jFields_t;

  // one fetched word, three ways to read it
  typedef union packed {
    rFields_t r;
    iFields_t i;
    jFields_t j;
  } instrWord_t;

endpackage

/* common/ctrlIf.sv */
// ====================
// decoder control levels toward pc logic and alu
// all signals are plain combinational levels, no handshake
// ====================
interface ctrlIf
  import mipsPkg::*;
  ();

  // destination rd instead of rt
  logic   regDst;
  // second operand from sign-extended imm
  logic   aluSrcImm;
  // write-back from data memory
  logic   memToReg;
  logic   regWrite;
  logic   memRead;
  logic   memWrite;
  logic   branch;
  logic   jump;
  // jr, next pc from rs
  logic   jumpReg;
  // jal, write pc+4 to linkReg
  logic   link;
  aluOp_t aluOp;

  modport decoder (
    output regDst, aluSrcImm, memToReg, regWrite, memRead, memWrite,
    output branch, jump, jumpReg, link, aluOp
  );

  modport datapath (
    input regDst, aluSrcImm, memToReg, regWrite, memRead, memWrite,
    input branch, jump, jumpReg, link, aluOp
  );

endinterface

/* common/regFileIf.sv */
// ====================
// two async read ports and one edge write port of the register file
// ====================
interface regFileIf
  import mipsPkg::*;
  ();

  // read side, addresses come from rs/rt
  logic [regAddrWidth-1:0] rdAddrA;
  logic [regAddrWidth-1:0] rdAddrB;
  logic [dataWidth-1:0]    rdDataA;
  logic [dataWidth-1:0]    rdDataB;

  // write side, sampled on rising clk
  logic                    wrEn;
  logic [regAddrWidth-1:0] wrAddr;
  logic [dataWidth-1:0]    wrData;

  // alu side
  modport client (
    input  rdDataA, rdDataB,
    output wrEn, wrAddr, wrData
  );

  // register array side
  modport store (
    input  rdAddrA, rdAddrB, wrEn, wrAddr, wrData,
    output rdDataA, rdDataB
  );

endinterface

/* src/controlDecoder.sv */
// ====================
// opcode and function-code decode in one pass
// anything outside the subset decodes as a no-op: all levels low, aluNone
// ====================
module controlDecoder
  import mipsPkg::*;
  (
  input  instrWord_t    instr,
  ctrlIf.decoder        ctrl
);

  always_comb begin
    // defaults give the no-op
    ctrl.regDst    = 1'b0;
    ctrl.aluSrcImm = 1'b0;
    ctrl.memToReg  = 1'b0;
    ctrl.regWrite  = 1'b0;
    ctrl.memRead   = 1'b0;
    ctrl.memWrite  = 1'b0;
    ctrl.branch    = 1'b0;
    ctrl.jump      = 1'b0;
    ctrl.jumpReg   = 1'b0;
    ctrl.link      = 1'b0;
    ctrl.aluOp     = aluNone;

    case (instr.r.opcode)
      opRType: begin
        // funct picks the operation
        case (instr.r.funct)
          fnAdd: begin
            ctrl.regDst   = 1'b1;
            ctrl.regWrite = 1'b1;
            ctrl.aluOp    = aluAdd;
          end
          fnSub: begin
            ctrl.regDst   = 1'b1;
            ctrl.regWrite = 1'b1;
            ctrl.aluOp    = aluSub;
          end
          fnAnd: begin
            ctrl.regDst   = 1'b1;
            ctrl.regWrite = 1'b1;
            ctrl.aluOp    = aluAnd;
          end
          fnOr: begin
            ctrl.regDst   = 1'b1;
            ctrl.regWrite = 1'b1;
            ctrl.aluOp    = aluOr;
          end
          fnSlt: begin
            ctrl.regDst   = 1'b1;
            ctrl.regWrite = 1'b1;
            ctrl.aluOp    = aluSlt;
          end
          // jr: pc from rs, nothing written
          fnJr: ctrl.jumpReg = 1'b1;
          default: ;
        endcase
      end
      opLw: begin
        ctrl.aluSrcImm = 1'b1;
        ctrl.memToReg  = 1'b1;
        ctrl.regWrite  = 1'b1;
        ctrl.memRead   = 1'b1;
        ctrl.aluOp     = aluAdd;
      end
      opSw: begin
        ctrl.aluSrcImm = 1'b1;
        ctrl.memWrite  = 1'b1;
        ctrl.aluOp     = aluAdd;
      end
      // equality via subtract and zero flag
      opBeq: begin
        ctrl.branch = 1'b1;
        ctrl.aluOp  = aluSub;
      end
      opJ: ctrl.jump = 1'b1;
      // link value is pc+4, no delay slot
      opJal: begin
        ctrl.jump     = 1'b1;
        ctrl.link     = 1'b1;
        ctrl.regWrite = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

/* src/pcUnit.sv */
// ====================
// pc register and next-pc mux, priority jr > j/jal > taken beq > pc+4
// ====================
module pcUnit
  import mipsPkg::*;
  (
  input  logic                 clk,
  input  logic                 rst,
  input  instrWord_t           instr,
  ctrlIf.datapath              ctrl,
  input  logic                 aluZero,
  // rs value, used by jr
  input  logic [dataWidth-1:0] jumpTarget,
  output logic [dataWidth-1:0] pc,
  output logic [dataWidth-1:0] pcPlus4
);

  logic [dataWidth-1:0] branchOffset;
  logic [dataWidth-1:0] nextPc;

  assign pcPlus4 = pc + 32'd4;

  // sign-extended imm, word offset to byte offset
  assign branchOffset = {{14{instr.i.imm[15]}}, instr.i.imm, 2'b00};

  // ==================== next pc
  always_comb begin
    if (ctrl.jumpReg) begin
      nextPc = jumpTarget;
    end else if (ctrl.jump) begin
      // region bits from pc+4
      nextPc = {pcPlus4[31:28], instr.j.target, 2'b00};
    end else if (ctrl.branch && aluZero) begin
      nextPc = pcPlus4 + branchOffset;
    end else begin
      nextPc = pcPlus4;
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pc <= '0;
    end else begin
      pc <= nextPc;
    end
  end

endmodule

/* src/regFile.sv */
// ====================
// 32 x 32 register file, async read, write on rising clk
// register zero always reads zero and never takes a write
// ====================
module regFile
  import mipsPkg::*;
  (
  input  logic      clk,
  input  logic      rst,
  regFileIf.store   rf
);

  localparam int numRegs = 2 ** regAddrWidth;

  logic [dataWidth-1:0] regs [numRegs];

  // ==================== write port
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int idx = 0; idx < numRegs; idx++) begin
        regs[idx] <= '0;
      end
    end else if (rf.wrEn && (rf.wrAddr != '0)) begin
      regs[rf.wrAddr] <= rf.wrData;
    end
  end

  // ==================== read ports
  // r0 forced to zero
  always_comb begin
    if (rf.rdAddrA == '0) begin
      rf.rdDataA = '0;
    end else begin
      rf.rdDataA = regs[rf.rdAddrA];
    end
  end

  always_comb begin
    if (rf.rdAddrB == '0) begin
      rf.rdDataB = '0;
    end else begin
      rf.rdDataB = regs[rf.rdAddrB];
    end
  end

endmodule

/* src/alu.sv */
// ====================
// operand select, the five alu ops, memory addressing and write-back select
// slt is signed; memAddr is a word address from result bits 8..2
// ====================
module alu
  import mipsPkg::*;
  (
  input  instrWord_t              instr,
  ctrlIf.datapath                 ctrl,
  regFileIf.client                rf,
  input  logic [dataWidth-1:0]    pcPlus4,
  input  logic [dataWidth-1:0]    memRdData,
  output logic                    aluZero,
  output logic [memAddrWidth-1:0] memAddr,
  output logic [dataWidth-1:0]    memWrData,
  output logic [dataWidth-1:0]    regWriteData
);

  logic [dataWidth-1:0]    immExt;
  logic [dataWidth-1:0]    opB;
  logic [dataWidth-1:0]    result;
  logic [regAddrWidth-1:0] destAddr;

  // ==================== execute
  assign immExt = {{16{instr.i.imm[15]}}, instr.i.imm};
  assign opB    = ctrl.aluSrcImm ? immExt : rf.rdDataB;

  always_comb begin
    case (ctrl.aluOp)
      aluAdd:  result = rf.rdDataA + opB;
      aluSub:  result = rf.rdDataA - opB;
      aluAnd:  result = rf.rdDataA & opB;
      aluOr:   result = rf.rdDataA | opB;
      aluSlt:  result = {31'd0, $signed(rf.rdDataA) < $signed(opB)};
      default: result = '0;
    endcase
  end

  // beq compares through the subtract
  assign aluZero = (result == '0);

  // byte offset bits dropped
  assign memAddr   = result[memAddrWidth+1:2];
  assign memWrData = rf.rdDataB;

  // ==================== write-back
  always_comb begin
    if (ctrl.link) begin
      destAddr = linkReg;
    end else if (ctrl.regDst) begin
      destAddr = instr.r.rd;
    end else begin
      destAddr = instr.i.rt;
    end
  end

  always_comb begin
    if (ctrl.link) begin
      regWriteData = pcPlus4;
    end else if (ctrl.memToReg) begin
      regWriteData = memRdData;
    end else begin
      regWriteData = result;
    end
  end

  // writes to r0 are dropped here so the strobe stays honest
  assign rf.wrEn   = ctrl.regWrite && (destAddr != '0);
  assign rf.wrAddr = destAddr;
  assign rf.wrData = regWriteData;

endmodule

/* src/mipsCore.sv */
// ====================
// single-cycle MIPS32 subset core, one instruction per clk
// instruction and data memories are external and must answer combinationally
// ====================
module mipsCore
  import mipsPkg::*;
  (
  input  logic                    clk,
  input  logic                    rst,
  // instruction memory
  output logic [dataWidth-1:0]    instrAddr,
  input  logic [dataWidth-1:0]    instr,
  // data memory, word addressed
  output logic [memAddrWidth-1:0] memAddr,
  output logic [dataWidth-1:0]    memWrData,
  input  logic [dataWidth-1:0]    memRdData,
  output logic                    memReadEn,
  output logic                    memWriteEn,
  // write-back observation
  output logic                    regWriteEn,
  output logic [regAddrWidth-1:0] regWriteAddr,
  output logic [dataWidth-1:0]    regWriteData
);

  instrWord_t           instrWord;
  logic [dataWidth-1:0] pcPlus4;
  logic                 aluZero;

  ctrlIf    ctrlBus ();
  regFileIf rfBus ();

  // ==================== fetch view
  assign instrWord = instr;

  // rs and rt feed the read ports for every format
  assign rfBus.rdAddrA = instrWord.r.rs;
  assign rfBus.rdAddrB = instrWord.r.rt;

  controlDecoder decodeUnit (
    .instr (instrWord),
    .ctrl  (ctrlBus)
  );

  // jr target is the rs read value
  pcUnit pcReg (
    .clk        (clk),
    .rst        (rst),
    .instr      (instrWord),
    .ctrl       (ctrlBus),
    .aluZero    (aluZero),
    .jumpTarget (rfBus.rdDataA),
    .pc         (instrAddr),
    .pcPlus4    (pcPlus4)
  );

  regFile regs (
    .clk (clk),
    .rst (rst),
    .rf  (rfBus)
  );

  alu execUnit (
    .instr        (instrWord),
    .ctrl         (ctrlBus),
    .rf           (rfBus),
    .pcPlus4      (pcPlus4),
    .memRdData    (memRdData),
    .aluZero      (aluZero),
    .memAddr      (memAddr),
    .memWrData    (memWrData),
    .regWriteData (regWriteData)
  );

  // ==================== observation and memory strobes
  assign memReadEn    = ctrlBus.memRead;
  assign memWriteEn   = ctrlBus.memWrite;
  assign regWriteEn   = rfBus.wrEn;
  assign regWriteAddr = rfBus.wrAddr;

endmodule

/* bench/isaModel.svh */
// ====================
// instruction-level reference model, included inside the testbench module
// caller keeps mMem filled like the data memory before the first step
// ====================
`ifndef isaModelSvh
`define isaModelSvh

// architectural state
logic [31:0] mPc;
logic [31:0] mRegs [32];
logic [31:0] mMem [128];

// expected core outputs for the word just stepped
logic        expRegWe;
logic [4:0]  expRegAddr;
logic [31:0] expRegData;
logic        expMemWe;
logic        expMemRe;
logic [6:0]  expMemAddr;
logic [31:0] expMemData;

task automatic resetModel();
  mPc = 32'd0;
  for (int k = 0; k < 32; k++) begin
    mRegs[5'(k)] = 32'd0;
  end
endtask

// r0 keeps zero and a write there is invisible
task automatic modelWrite(input logic [4:0] idx, input logic [31:0] val);
  if (idx != 5'd0) begin
    expRegWe   = 1'b1;
    expRegAddr = idx;
    expRegData = val;
    mRegs[idx] = val;
  end
endtask

task automatic stepModel(input logic [31:0] word);
  logic [5:0]  op;
  logic [5:0]  fn;
  logic [4:0]  rs;
  logic [4:0]  rt;
  logic [4:0]  rd;
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] simm;
  logic [31:0] seqPc;
  logic [31:0] nextPc;
  logic [31:0] ea;
  op     = word[31:26];
  rs     = word[25:21];
  rt     = word[20:16];
  rd     = word[15:11];
  fn     = word[5:0];
  a      = mRegs[rs];
  b      = mRegs[rt];
  simm   = {{16{word[15]}}, word[15:0]};
  seqPc  = mPc + 32'd4;
  nextPc = seqPc;
  expRegWe   = 1'b0;
  expRegAddr = 5'd0;
  expRegData = 32'd0;
  expMemWe   = 1'b0;
  expMemRe   = 1'b0;
  expMemAddr = 7'd0;
  expMemData = 32'd0;
  case (op)
    // special: funct selects
    6'h00: begin
      case (fn)
        6'h20: modelWrite(rd, a + b);
        6'h22: modelWrite(rd, a - b);
        6'h24: modelWrite(rd, a & b);
        6'h25: modelWrite(rd, a | b);
        6'h2a: modelWrite(rd, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
        6'h08: nextPc = a;
        default: ;
      endcase
    end
    // lw, word address from bits 8..2
    6'h23: begin
      ea       = a + simm;
      expMemRe = 1'b1;
      modelWrite(rt, mMem[ea[8:2]]);
    end
    6'h2b: begin
      ea              = a + simm;
      expMemWe        = 1'b1;
      expMemAddr      = ea[8:2];
      expMemData      = b;
      mMem[ea[8:2]]   = b;
    end
    6'h04: begin
      if (a == b) begin
        nextPc = seqPc + {simm[29:0], 2'b00};
      end
    end
    6'h02: nextPc = {seqPc[31:28], word[25:0], 2'b00};
    // jal links pc+4
    6'h03: begin
      modelWrite(5'd31, seqPc);
      nextPc = {seqPc[31:28], word[25:0], 2'b00};
    end
    default: ;
  endcase
  mPc = nextPc;
endtask

`endif

/* bench/mipsCoreTb.sv */
// ====================
// random program run against the included ISA model, then register readback
// branches and jumps only go forward; the closing j 0 keeps the core looping
// ====================
module mipsCoreTb
  import mipsPkg::*;
  ();

  localparam int runCycles  = 2000;
  localparam int progLen    = 200;
  localparam int resetLimit = 10;
  // jr target slots at the top of data memory that sw never reaches
  localparam int slotBase   = 120;
  // only lw of a slot writes this register
  localparam int jrReg      = 30;

  logic        clk;
  logic        rst;
  logic [31:0] instrAddr;
  logic [31:0] instr;
  logic [6:0]  memAddr;
  logic [31:0] memWrData;
  logic [31:0] memRdData;
  logic        memReadEn;
  logic        memWriteEn;
  logic        regWriteEn;
  logic [4:0]  regWriteAddr;
  logic [31:0] regWriteData;

  logic [31:0] imem [256];
  logic [31:0] dataMem [128];
  logic [31:0] imemWord;
  logic        readback;
  logic [31:0] rbWord;
  logic [31:0] rngState;
  // pc, reg write, memory, readback
  int          errCounts [4];

  `include "isaModel.svh"

  mipsCore uut (
    .clk          (clk),
    .rst          (rst),
    .instrAddr    (instrAddr),
    .instr        (instr),
    .memAddr      (memAddr),
    .memWrData    (memWrData),
    .memRdData    (memRdData),
    .memReadEn    (memReadEn),
    .memWriteEn   (memWriteEn),
    .regWriteEn   (regWriteEn),
    .regWriteAddr (regWriteAddr),
    .regWriteData (regWriteData)
  );

  // ==================== memory models
  // zero outside the 256-word array
  assign imemWord  = (instrAddr[31:10] == 22'd0) ? imem[instrAddr[9:2]] : 32'd0;
  assign instr     = readback ? rbWord : imemWord;
  assign memRdData = dataMem[memAddr];

  always @(posedge clk) begin
    if (memWriteEn) begin
      dataMem[memAddr] <= memWrData;
    end
  end

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ==================== stimulus helpers
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic nextRand(output logic [31:0] r);
    rngState = xorshift32(rngState);
    r = rngState;
  endtask

  function automatic logic [31:0] rWord(input logic [4:0] rs, rt, rd, input logic [5:0] fn);
    return {opRType, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic logic [31:0] iWord(input logic [5:0] op, input logic [4:0] rs, rt,
                                        input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic logic [31:0] jWord(input logic [5:0] op, input int idx);
    return {op, 26'(idx)};
  endfunction

  function automatic logic [5:0] pickFn(input logic [2:0] k);
    case (k)
      3'd0, 3'd5: return fnAdd;
      3'd1, 3'd6: return fnSub;
      3'd2: return fnAnd;
      3'd3: return fnOr;
      default: return fnSlt;
    endcase
  endfunction

  // keeps the jr register out of reach of ordinary writes
  function automatic logic [4:0] freeDest(input logic [4:0] r);
    return (r == 5'(jrReg)) ? 5'd29 : r;
  endfunction

  task automatic fillDataMemory();
    logic [31:0] r;
    for (int k = 0; k < 128; k++) begin
      nextRand(r);
      dataMem[7'(k)] <= r;
      mMem[7'(k)]    = r;
    end
  endtask

  task automatic buildProgram();
    logic [31:0] sel;
    logic [31:0] a;
    logic [31:0] b;
    logic [5:0]  code;
    int          p;
    int          tgt;
    int          slot;
    for (int k = 0; k < 256; k++) begin
      imem[8'(k)] = 32'd0;
    end
    p    = 0;
    slot = 0;
    while (p < progLen - 1) begin
      nextRand(sel);
      nextRand(a);
      nextRand(b);
      // forward target inside the program
      tgt = p + 1 + int'(b % 32'(progLen - 1 - p));
      case (sel[3:0])
        4'd6, 4'd7: imem[8'(p)] = iWord(opLw, 5'd0, freeDest(a[4:0]), {7'd0, a[13:7], 2'b00});
        4'd8: imem[8'(p)] = iWord(opSw, 5'd0, a[4:0], {7'd0, 7'(a[13:7] % 7'd120), 2'b00});
        // small register set, so equal operands happen
        4'd9: imem[8'(p)] = iWord(opBeq, {3'd0, a[1:0]}, {3'd0, a[3:2]}, 16'(tgt - p - 1));
        4'd10: imem[8'(p)] = jWord(opJ, tgt);
        4'd11: imem[8'(p)] = jWord(opJal, tgt);
        4'd12: begin
          if (slot < 8 && p < progLen - 2) begin
            // lw of a slot, then jr past the pair
            tgt = p + 2 + int'(b % 32'(progLen - 2 - p));
            dataMem[7'(slotBase + slot)] <= 32'(tgt * 4);
            mMem[7'(slotBase + slot)]    = 32'(tgt * 4);
            imem[8'(p)] = iWord(opLw, 5'd0, 5'(jrReg), 16'((slotBase + slot) * 4));
            p = p + 1;
            imem[8'(p)] = rWord(5'(jrReg), 5'd0, 5'd0, fnJr);
            slot++;
          end else begin
            imem[8'(p)] = 32'd0;
          end
        end
        4'd13: begin
          code = a[31:26];
          if (code inside {opRType, opLw, opSw, opBeq, opJ, opJal}) begin
            code = 6'h3f;
          end
          imem[8'(p)] = {code, a[25:0]};
        end
        4'd14: begin
          code = a[5:0];
          if (code inside {fnAdd, fnSub, fnAnd, fnOr, fnSlt, fnJr}) begin
            code = 6'h3f;
          end
          imem[8'(p)] = {opRType, a[25:6], code};
        end
        default: imem[8'(p)] = rWord(a[4:0], a[9:5], freeDest(a[14:10]), pickFn(a[17:15]));
      endcase
      p++;
    end
    imem[8'(progLen - 1)] = jWord(opJ, 0);
  endtask

  // ==================== checks
  task automatic compareValue(input string name, input logic [31:0] got,
                              input logic [31:0] expected, input int cat);
    assert (got === expected) else begin
      errCounts[2'(cat)]++;
      $display("error: %s got %h expected %h", name, got, expected);
    end
  endtask

  // sampled at the falling edge with one model step per fetched word
  task automatic checkCycle();
    compareValue("instrAddr", instrAddr, mPc, 0);
    stepModel(instr);
    compareValue("regWriteEn", 32'(regWriteEn), 32'(expRegWe), 1);
    if (expRegWe) begin
      compareValue("regWriteAddr", 32'(regWriteAddr), 32'(expRegAddr), 1);
      compareValue("regWriteData", regWriteData, expRegData, 1);
    end
    compareValue("memWriteEn", 32'(memWriteEn), 32'(expMemWe), 2);
    if (expMemWe) begin
      compareValue("memAddr", 32'(memAddr), 32'(expMemAddr), 2);
      compareValue("memWrData", memWrData, expMemData, 2);
    end
    compareValue("memReadEn", 32'(memReadEn), 32'(expMemRe), 2);
  endtask

  task automatic runProgram();
    checkCycle();
    repeat (runCycles - 1) begin
      @(negedge clk);
      checkCycle();
    end
  endtask

  // add rk, rk, r0 shows rk on the write-back port
  task automatic readAllRegisters();
    for (int k = 1; k < 32; k++) begin
      @(posedge clk);
      readback <= 1'b1;
      rbWord   <= rWord(5'(k), 5'd0, 5'(k), fnAdd);
      @(negedge clk);
      compareValue("regWriteEn", 32'(regWriteEn), 32'd1, 3);
      compareValue("regWriteAddr", 32'(regWriteAddr), 32'(k), 3);
      compareValue("regWriteData", regWriteData, mRegs[5'(k)], 3);
    end
  endtask

  // ==================== main sequence
  initial begin
    int waitCount;
    bit timedOut;
    rst      <= 1'b0;
    readback <= 1'b0;
    rbWord   <= 32'd0;
    rngState = 32'd4;
    timedOut = 1'b0;
    for (int k = 0; k < 4; k++) begin
      errCounts[2'(k)] = 0;
    end
    fillDataMemory();
    buildProgram();
    resetModel();
    repeat (3) @(posedge clk);
    rst <= 1'b1;
    // released and the core fetching from address zero
    waitCount = 0;
    while ((rst !== 1'b1 || instrAddr !== 32'd0) && waitCount < resetLimit) begin
      @(negedge clk);
      waitCount++;
    end
    if (rst !== 1'b1 || instrAddr !== 32'd0) begin
      timedOut = 1'b1;
      $display("core did not come out of reset at address zero within %0d cycles",
               resetLimit);
    end else begin
      runProgram();
      readAllRegisters();
    end
    $display("errors: pc %0d, reg write %0d, memory %0d, readback %0d",
             errCounts[0], errCounts[1], errCounts[2], errCounts[3]);
    if (timedOut || (errCounts[0] + errCounts[1] + errCounts[2] + errCounts[3]) != 0) begin
      $display("STATUS: FAIL");
    end else begin
      $display("STATUS: PASS");
    end
    $finish;
  end

endmodule

/* flist.f */
+incdir+bench
common/mipsPkg.sv
common/ctrlIf.sv
common/regFileIf.sv
src/controlDecoder.sv
src/pcUnit.sv
src/regFile.sv
src/alu.sv
src/mipsCore.sv
bench/mipsCoreTb.sv

/* run.sh */
#!/bin/sh
# build and run the mipsCore testbench with Verilator

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
simName=mipsCoreSim
logFile=sim.log

verilator --binary --timing --assert -f flist.f --top-module mipsCoreTb \
  -Mdir "$buildDir" -o "$simName"
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$buildDir/$simName" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
  echo "simulation exited with status $simStatus"
  exit 1
fi

if grep -q "^STATUS: PASS$" "$logFile"; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed, see $logFile"
  exit 1
fi
